// File: rtl/cmoc_pkg.sv
package cmoc_pkg;

	// Local bus geometry
	localparam int LB_AW = 17;
	localparam int LB_DW = 32;

	// Address bit that selects the simulator half (upper 16K words)
	localparam int REGION_BIT = 14;

	localparam int MODE_COUNT = 3;
	localparam int AMP_W = 18;

	// Wide enough for any shift across a full amplitude word
	localparam int SHIFT_W = $clog2(AMP_W + 1);

	// Controller flat register map
	localparam int REG_SP0 = 0;
	localparam int REG_KP0 = 3;
	localparam int REG_EN = 6;
	localparam int REG_DRV0 = 7;

	// Simulator per-mode fields
	localparam int FLD_DECAY = 0;
	localparam int FLD_AMP = 1;

	localparam logic [SHIFT_W-1:0] DECAY_RST = 3;
	localparam logic [SHIFT_W-1:0] KP_RST = 2;

	localparam logic [LB_DW-1:0] LB_UNMAPPED = 32'hdead_beef;

	// Strobe to read-valid, in clocks
	localparam int RD_LATENCY = 3;

	typedef logic signed [AMP_W-1:0] amp_t;

	// Same address word, seen by the controller as a flat register number
	// and by the simulator as mode plus field
	typedef union packed {
		struct packed {
			logic [LB_AW-REGION_BIT-2:0] upper;
			logic region;
			logic [REGION_BIT-9:0] pad;
			logic [7:0] reg_num;
		} ctl;
		struct packed {
			logic [LB_AW-REGION_BIT-2:0] upper;
			logic region;
			logic [REGION_BIT-9:0] pad;
			logic [3:0] mode;
			logic [3:0] field;
		} sim;
	} lb_addr_u;

endpackage

// File: rtl/lb_port_if.sv
// One decoded region port of the local bus
interface lb_port_if
	import cmoc_pkg::*;
();

	lb_addr_u addr;
	logic [LB_DW-1:0] wdata;

	// Single-cycle pulses, only on the selected region
	logic write;
	logic read;

	// Registered by the target one clock after read
	logic [LB_DW-1:0] rdata;

	modport host (
		output addr,
		output wdata,
		output write,
		output read,
		input rdata
	);

	modport target (
		input addr,
		input wdata,
		input write,
		input read,
		output rdata
	);

endinterface

// File: rtl/lb_decode.sv
module lb_decode
	import cmoc_pkg::*;
(
	input logic lb_clk,
	input logic rst_n,
	input logic [LB_AW-1:0] lb_addr,
	input logic [LB_DW-1:0] lb_data,
	input logic lb_strobe,
	input logic lb_write,
	input logic lb_read,
	lb_port_if.host ctl_port,
	lb_port_if.host sim_port,
	output logic tag_valid,
	output logic tag_region
);

	lb_addr_u addr_u;
	logic sel_sim;
	logic wr_req;
	logic rd_req;

	assign addr_u = lb_addr;

	// Region bit sits at the same place in both views
	assign sel_sim = addr_u.ctl.region;

	assign wr_req = lb_strobe & lb_write;
	assign rd_req = lb_strobe & lb_read;

	// Address and data fan out to both regions
	always_ff @(posedge lb_clk) begin
		ctl_port.addr <= addr_u;
		ctl_port.wdata <= lb_data;
		sim_port.addr <= addr_u;
		sim_port.wdata <= lb_data;
	end

	// Only the addressed region sees a pulse
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			ctl_port.write <= 1'b0;
			ctl_port.read <= 1'b0;
			sim_port.write <= 1'b0;
			sim_port.read <= 1'b0;
		end else begin
			ctl_port.write <= wr_req & ~sel_sim;
			ctl_port.read <= rd_req & ~sel_sim;
			sim_port.write <= wr_req & sel_sim;
			sim_port.read <= rd_req & sel_sim;
		end
	end

	// Read tag travels alongside the port read toward the return mux
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			tag_valid <= 1'b0;
			tag_region <= 1'b0;
		end else begin
			tag_valid <= rd_req;
			tag_region <= sel_sim;
		end
	end

endmodule

// File: rtl/field_ctl.sv
module field_ctl
	import cmoc_pkg::*;
(
	input logic lb_clk,
	input logic rst_n,
	lb_port_if.target port,
	input amp_t amp [MODE_COUNT],
	output amp_t drive [MODE_COUNT]
);

	amp_t sp [MODE_COUNT];
	logic [SHIFT_W-1:0] kp [MODE_COUNT];
	logic [MODE_COUNT-1:0] en;

	logic signed [AMP_W:0] err [MODE_COUNT];
	logic signed [AMP_W+1:0] sum [MODE_COUNT];

	logic [7:0] reg_num;
	logic map_ok;
	logic [LB_DW-1:0] rd_word;

	// Clamp to the signed amplitude range
	function automatic amp_t sat_amp(input logic signed [AMP_W+1:0] x);
		if (x[AMP_W+1:AMP_W-1] == '0 || x[AMP_W+1:AMP_W-1] == '1)
			return x[AMP_W-1:0];
		else if (x[AMP_W+1])
			return {1'b1, {(AMP_W-1){1'b0}}};
		else
			return {1'b0, {(AMP_W-1){1'b1}}};
	endfunction

	assign reg_num = port.addr.ctl.reg_num;
	assign map_ok = (port.addr.ctl.pad == '0);

	// Host register writes
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			for (int m = 0; m < MODE_COUNT; m++) begin
				sp[m] <= '0;
				kp[m] <= KP_RST;
			end
			en <= '0;
		end else if (port.write && map_ok) begin
			for (int m = 0; m < MODE_COUNT; m++) begin
				if (reg_num == REG_SP0 + m)
					sp[m] <= port.wdata[AMP_W-1:0];
				if (reg_num == REG_KP0 + m)
					kp[m] <= port.wdata[SHIFT_W-1:0];
			end
			if (reg_num == REG_EN)
				en <= port.wdata[MODE_COUNT-1:0];
		end
	end

	// Proportional correction around the setpoint
	always_comb begin
		for (int m = 0; m < MODE_COUNT; m++) begin
			err[m] = sp[m] - amp[m];
			sum[m] = sp[m] + (err[m] >>> kp[m]);
		end
	end

	// Disabled modes just pass the setpoint through as feed-forward
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			for (int m = 0; m < MODE_COUNT; m++)
				drive[m] <= '0;
		end else begin
			for (int m = 0; m < MODE_COUNT; m++)
				drive[m] <= en[m] ? sat_amp(sum[m]) : sp[m];
		end
	end

	// Readback decode, drives are read only
	always_comb begin
		rd_word = LB_UNMAPPED;
		if (map_ok) begin
			for (int m = 0; m < MODE_COUNT; m++) begin
				if (reg_num == REG_SP0 + m)
					rd_word = LB_DW'(sp[m]);
				if (reg_num == REG_KP0 + m)
					rd_word = LB_DW'(kp[m]);
				if (reg_num == REG_DRV0 + m)
					rd_word = LB_DW'(drive[m]);
			end
			if (reg_num == REG_EN)
				rd_word = LB_DW'(en);
		end
	end

	always_ff @(posedge lb_clk) begin
		if (port.read)
			port.rdata <= rd_word;
	end

endmodule

// File: rtl/cav_sim.sv
module cav_sim
	import cmoc_pkg::*;
(
	input logic lb_clk,
	input logic rst_n,
	lb_port_if.target port,
	input amp_t drive [MODE_COUNT],
	output amp_t amp [MODE_COUNT]
);

	logic [SHIFT_W-1:0] decay [MODE_COUNT];

	logic signed [AMP_W:0] diff [MODE_COUNT];
	logic signed [AMP_W:0] next_sum [MODE_COUNT];

	logic [3:0] mode;
	logic [3:0] field;
	logic map_ok;
	logic [LB_DW-1:0] rd_word;

	assign mode = port.addr.sim.mode;
	assign field = port.addr.sim.field;
	assign map_ok = (port.addr.sim.pad == '0);

	// First-order step toward the drive
	// Result always lies between amp and drive, so no saturation is needed
	always_comb begin
		for (int m = 0; m < MODE_COUNT; m++) begin
			diff[m] = drive[m] - amp[m];
			next_sum[m] = amp[m] + (diff[m] >>> decay[m]);
		end
	end

	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			for (int m = 0; m < MODE_COUNT; m++)
				amp[m] <= '0;
		end else begin
			for (int m = 0; m < MODE_COUNT; m++) begin
				amp[m] <= next_sum[m][AMP_W-1:0];
				// Host clear wins over the update
				if (port.write && map_ok && mode == m && field == FLD_AMP)
					amp[m] <= '0;
			end
		end
	end

	// Decay shift per mode
	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			for (int m = 0; m < MODE_COUNT; m++)
				decay[m] <= DECAY_RST;
		end else if (port.write && map_ok && field == FLD_DECAY) begin
			for (int m = 0; m < MODE_COUNT; m++) begin
				if (mode == m)
					decay[m] <= port.wdata[SHIFT_W-1:0];
			end
		end
	end

	// Mode indices past MODE_COUNT never match and fall to unmapped
	always_comb begin
		rd_word = LB_UNMAPPED;
		if (map_ok) begin
			for (int m = 0; m < MODE_COUNT; m++) begin
				if (mode == m && field == FLD_DECAY)
					rd_word = LB_DW'(decay[m]);
				if (mode == m && field == FLD_AMP)
					rd_word = LB_DW'(amp[m]);
			end
		end
	end

	always_ff @(posedge lb_clk) begin
		if (port.read)
			port.rdata <= rd_word;
	end

endmodule

// File: rtl/lb_read_mux.sv
module lb_read_mux
	import cmoc_pkg::*;
(
	input logic lb_clk,
	input logic rst_n,
	input logic [LB_DW-1:0] ctl_rdata,
	input logic [LB_DW-1:0] sim_rdata,
	input logic tag_valid,
	input logic tag_region,
	output logic lb_rd_valid,
	output logic [LB_DW-1:0] lb_out
);

	// Tag delayed one clock to meet the targets' registered rdata
	logic tag_valid_q;
	logic tag_region_q;

	always_ff @(posedge lb_clk) begin
		if (!rst_n) begin
			tag_valid_q <= 1'b0;
			lb_rd_valid <= 1'b0;
		end else begin
			tag_valid_q <= tag_valid;
			lb_rd_valid <= tag_valid_q;
		end
	end

	always_ff @(posedge lb_clk) begin
		tag_region_q <= tag_region;
	end

	// Return data holds between reads
	always_ff @(posedge lb_clk) begin
		if (tag_valid_q)
			lb_out <= tag_region_q ? sim_rdata : ctl_rdata;
	end

endmodule

// File: rtl/cryomodule.sv
module cryomodule
	import cmoc_pkg::*;
(
	input logic lb_clk,
	input logic rst_n,
	input logic [LB_AW-1:0] lb_addr,
	input logic [LB_DW-1:0] lb_data,
	input logic lb_strobe,
	input logic lb_write,
	input logic lb_read,
	output logic lb_rd_valid,
	output logic [LB_DW-1:0] lb_out
);

	lb_port_if ctl_port ();
	lb_port_if sim_port ();

	logic tag_valid;
	logic tag_region;

	// Field loop between controller and simulator
	amp_t drive [MODE_COUNT];
	amp_t amp [MODE_COUNT];

	lb_decode u_decode (
		.lb_clk(lb_clk),
		.rst_n(rst_n),
		.lb_addr(lb_addr),
		.lb_data(lb_data),
		.lb_strobe(lb_strobe),
		.lb_write(lb_write),
		.lb_read(lb_read),
		.ctl_port(ctl_port),
		.sim_port(sim_port),
		.tag_valid(tag_valid),
		.tag_region(tag_region)
	);

	// Lower half of the address space
	field_ctl u_ctl (
		.lb_clk(lb_clk),
		.rst_n(rst_n),
		.port(ctl_port),
		.amp(amp),
		.drive(drive)
	);

	// Upper half
	cav_sim u_sim (
		.lb_clk(lb_clk),
		.rst_n(rst_n),
		.port(sim_port),
		.drive(drive),
		.amp(amp)
	);

	lb_read_mux u_rmux (
		.lb_clk(lb_clk),
		.rst_n(rst_n),
		.ctl_rdata(ctl_port.rdata),
		.sim_rdata(sim_port.rdata),
		.tag_valid(tag_valid),
		.tag_region(tag_region),
		.lb_rd_valid(lb_rd_valid),
		.lb_out(lb_out)
	);

endmodule

// File: test/cryomodule_asserts.sv
module cryomodule_asserts
	import cmoc_pkg::*;
(
	input logic lb_clk,
	input logic rst_n,
	input logic lb_strobe,
	input logic lb_read,
	input logic lb_rd_valid,
	input logic ctl_write,
	input logic ctl_read,
	input logic sim_write,
	input logic sim_read
);

	// Valid is sampled one edge after the third register has taken the strobe
	assert property (@(posedge lb_clk) disable iff (!rst_n)
		lb_strobe && lb_read |-> ##(RD_LATENCY) lb_rd_valid)
	else $error("lb_rd_valid missing after read strobe");

	assert property (@(posedge lb_clk) disable iff (!rst_n)
		lb_rd_valid |-> $past(lb_strobe && lb_read, RD_LATENCY))
	else $error("lb_rd_valid without matching read strobe");

	assert property (@(posedge lb_clk) !rst_n |=> !lb_rd_valid)
	else $error("lb_rd_valid high during reset");

	// Only one region sees a pulse on any clock
	assert property (@(posedge lb_clk) disable iff (!rst_n)
		$onehot0({ctl_write, ctl_read, sim_write, sim_read}))
	else $error("more than one port pulse in a cycle");

endmodule

bind cryomodule cryomodule_asserts u_asserts (
	.lb_clk(lb_clk),
	.rst_n(rst_n),
	.lb_strobe(lb_strobe),
	.lb_read(lb_read),
	.lb_rd_valid(lb_rd_valid),
	.ctl_write(ctl_port.write),
	.ctl_read(ctl_port.read),
	.sim_write(sim_port.write),
	.sim_read(sim_port.read)
);

// File: test/cryomodule_tb.sv
module cryomodule_tb
	import cmoc_pkg::*;
();

	typedef enum logic [1:0] {OP_WR, OP_RD, OP_IDLE} op_e;

	typedef struct {
		op_e op;
		logic [LB_AW-1:0] addr;
		logic [LB_DW-1:0] data;
		logic [LB_DW-1:0] exp;
		int tol;
		string what;
	} step_t;

	logic lb_clk;
	logic rst_n;
	logic [LB_AW-1:0] lb_addr;
	logic [LB_DW-1:0] lb_data;
	logic lb_strobe;
	logic lb_write;
	logic lb_read;
	logic lb_rd_valid;
	logic [LB_DW-1:0] lb_out;

	step_t steps[$];
	logic [LB_DW-1:0] exp_q[$];
	int tol_q[$];
	string what_q[$];
	logic [RD_LATENCY-1:0] rd_pipe;

	int value_errors = 0;
	int bus_errors = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int settle_cycles = 0;

	// Shifts per mode, and distinct setpoints for the loop tests
	int kp_tab[MODE_COUNT] = '{1, 2, 1};
	int decay_tab[MODE_COUNT] = '{3, 4, 2};
	int sp_tab[MODE_COUNT] = '{20000, 12000, 5000};

	cryomodule DUT (
		.lb_clk(lb_clk),
		.rst_n(rst_n),
		.lb_addr(lb_addr),
		.lb_data(lb_data),
		.lb_strobe(lb_strobe),
		.lb_write(lb_write),
		.lb_read(lb_read),
		.lb_rd_valid(lb_rd_valid),
		.lb_out(lb_out)
	);

	always #5 lb_clk = ~lb_clk;

	function automatic logic [LB_AW-1:0] ctl_addr(input int reg_num);
		return LB_AW'(reg_num);
	endfunction

	// Region bit set, mode in bits 7:4, field in bits 3:0
	function automatic logic [LB_AW-1:0] sim_addr(input int mode, input int field);
		return LB_AW'((1 << REGION_BIT) | (mode << 4) | field);
	endfunction

	function automatic logic [LB_DW-1:0] sext_amp(input logic [LB_DW-1:0] w);
		return {{(LB_DW - AMP_W){w[AMP_W-1]}}, w[AMP_W-1:0]};
	endfunction

	function automatic void write_step(input logic [LB_AW-1:0] addr, input logic [LB_DW-1:0] data);
		steps.push_back('{OP_WR, addr, data, '0, 0, "write"});
	endfunction

	function automatic void read_step(input logic [LB_AW-1:0] addr, input logic [LB_DW-1:0] exp,
		input int tol, input string what);
		steps.push_back('{OP_RD, addr, '0, exp, tol, what});
	endfunction

	function automatic void idle_step(input int n);
		steps.push_back('{OP_IDLE, '0, LB_DW'(n), '0, 0, "idle"});
		settle_cycles += n;
	endfunction

	task automatic build_table();
		logic [LB_DW-1:0] r [MODE_COUNT];
		// Reset values
		for (int m = 0; m < MODE_COUNT; m++) begin
			read_step(ctl_addr(REG_KP0 + m), LB_DW'(KP_RST), 0, $sformatf("reset kp %0d", m));
			read_step(sim_addr(m, FLD_DECAY), LB_DW'(DECAY_RST), 0, $sformatf("reset decay %0d", m));
			read_step(ctl_addr(REG_DRV0 + m), '0, 0, $sformatf("reset drive %0d", m));
			read_step(sim_addr(m, FLD_AMP), '0, 0, $sformatf("reset amp %0d", m));
		end
		read_step(ctl_addr(REG_EN), '0, 0, "reset enable");
		// Write both regions, then read back on consecutive clocks
		for (int m = 0; m < MODE_COUNT; m++) begin
			r[m] = $urandom;
			write_step(ctl_addr(REG_SP0 + m), r[m]);
			write_step(ctl_addr(REG_KP0 + m), LB_DW'(kp_tab[m]));
			write_step(sim_addr(m, FLD_DECAY), LB_DW'(decay_tab[m]));
		end
		for (int m = 0; m < MODE_COUNT; m++) begin
			read_step(ctl_addr(REG_SP0 + m), sext_amp(r[m]), 0, $sformatf("setpoint %0d", m));
			read_step(ctl_addr(REG_KP0 + m), LB_DW'(kp_tab[m]), 0, $sformatf("kp %0d", m));
			read_step(sim_addr(m, FLD_DECAY), LB_DW'(decay_tab[m]), 0, $sformatf("decay %0d", m));
		end
		// Unmapped locations
		read_step(ctl_addr(10), LB_UNMAPPED, 0, "ctl reg 10");
		read_step(ctl_addr(255), LB_UNMAPPED, 0, "ctl reg 255");
		read_step(sim_addr(3, FLD_DECAY), LB_UNMAPPED, 0, "sim mode 3 decay");
		read_step(sim_addr(3, FLD_AMP), LB_UNMAPPED, 0, "sim mode 3 amp");
		read_step(sim_addr(15, FLD_AMP), LB_UNMAPPED, 0, "sim mode 15 amp");
		read_step(sim_addr(0, 2), LB_UNMAPPED, 0, "sim mode 0 field 2");
		// Open loop, drive follows setpoint and ignores writes
		for (int m = 0; m < MODE_COUNT; m++)
			write_step(ctl_addr(REG_SP0 + m), LB_DW'(sp_tab[m]));
		idle_step(2);
		for (int m = 0; m < MODE_COUNT; m++) begin
			read_step(ctl_addr(REG_DRV0 + m), LB_DW'(sp_tab[m]), 0, $sformatf("open drive %0d", m));
			write_step(ctl_addr(REG_DRV0 + m), 32'h0001_2345);
			read_step(ctl_addr(REG_DRV0 + m), LB_DW'(sp_tab[m]), 0, $sformatf("ro drive %0d", m));
		end
		idle_step(300);
		for (int m = 0; m < MODE_COUNT; m++)
			read_step(sim_addr(m, FLD_AMP), LB_DW'(sp_tab[m]), 1 << decay_tab[m],
				$sformatf("open amp %0d", m));
		// Closed loop on all modes
		write_step(ctl_addr(REG_EN), LB_DW'(3'b111));
		idle_step(400);
		for (int m = 0; m < MODE_COUNT; m++)
			read_step(sim_addr(m, FLD_AMP), LB_DW'(sp_tab[m]), 16, $sformatf("closed amp %0d", m));
		// Clear mode 0 and watch it recover, well clear of the settled level
		write_step(sim_addr(0, FLD_AMP), '0);
		read_step(sim_addr(0, FLD_AMP), '0, sp_tab[0] / 2, "amp 0 after clear");
		idle_step(400);
		read_step(sim_addr(0, FLD_AMP), LB_DW'(sp_tab[0]), 16, "amp 0 recovered");
		idle_step(1);
	endtask

	task automatic apply_step(input step_t s);
		@(negedge lb_clk);
		lb_strobe = (s.op != OP_IDLE);
		lb_write = (s.op == OP_WR);
		lb_read = (s.op == OP_RD);
		lb_addr = s.addr;
		lb_data = s.data;
		if (s.op == OP_RD) begin
			exp_q.push_back(s.exp);
			tol_q.push_back(s.tol);
			what_q.push_back(s.what);
		end
		if (s.op == OP_IDLE)
			repeat (s.data - 1) @(negedge lb_clk);
	endtask

	task automatic check_value(input logic [LB_DW-1:0] got, input logic [LB_DW-1:0] exp,
		input int tol, input string what);
		bit ok;
		longint diff;
		ok = (got === exp);
		if (!ok && tol > 0 && !$isunknown(got)) begin
			diff = longint'(signed'(got)) - longint'(signed'(exp));
			ok = (diff <= tol) && (diff >= -tol);
		end
		if (!ok) begin
			$display("FAIL t=%0t %s: got %h expected %h tol %0d", $time, what, got, exp, tol);
			value_errors++;
		end
	endtask

	// Read strobes seen by the DUT, aged one stage per clock
	always @(posedge lb_clk) begin
		if (!rst_n)
			rd_pipe <= '0;
		else
			rd_pipe <= {rd_pipe[RD_LATENCY-2:0], lb_strobe & lb_read};
	end

	always @(negedge lb_clk) begin
		if (rd_pipe[RD_LATENCY-1] && exp_q.size() == 0) begin
			$display("Read at %0t has no expected value queued", $time);
			bus_errors++;
		end else if (rd_pipe[RD_LATENCY-1]) begin
			if (lb_rd_valid !== 1'b1) begin
				$display("Read-valid never arrived for %s at %0t", what_q[0], $time);
				bus_errors++;
				void'(exp_q.pop_front());
				void'(tol_q.pop_front());
				void'(what_q.pop_front());
			end else begin
				check_value(lb_out, exp_q.pop_front(), tol_q.pop_front(), what_q.pop_front());
			end
		end else if (lb_rd_valid === 1'b1) begin
			$display("Read-valid arrived at %0t with no read outstanding", $time);
			bus_errors++;
		end
	end

	always @(posedge lb_clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d clock cycles", cycle_limit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		lb_clk = 1'b0;
		rst_n = 1'b0;
		lb_addr = '0;
		lb_data = '0;
		lb_strobe = 1'b0;
		lb_write = 1'b0;
		lb_read = 1'b0;
		void'($urandom(32'h9d2d));
		build_table();
		cycle_limit = steps.size() * 8 + settle_cycles + 4 + 100;
		repeat (4) @(negedge lb_clk);
		rst_n = 1'b1;
		foreach (steps[i])
			apply_step(steps[i]);
		repeat (RD_LATENCY + 2) @(negedge lb_clk);
		if (exp_q.size() != 0) begin
			$display("%0d reads still waiting for read-valid at end of run", exp_q.size());
			bus_errors++;
		end
		$display("Errors: %0d value mismatches, %0d bus errors", value_errors, bus_errors);
		if (value_errors == 0 && bus_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: cmoc.f
rtl/cmoc_pkg.sv
rtl/lb_port_if.sv
rtl/lb_decode.sv
rtl/field_ctl.sv
rtl/cav_sim.sv
rtl/lb_read_mux.sv
rtl/cryomodule.sv
test/cryomodule_asserts.sv
test/cryomodule_tb.sv
